// ==== logic/mcu_cfg_pkg.sv ====
/*
 * Chip-level constants. Interrupt positions follow the mip layout of the core.
 * DOM_IDX_W bounds the number of power domains a command can address.
 */
`default_nettype none

package mcu_cfg_pkg;

  // machine interrupt vector
  localparam int unsigned IRQ_W      = 32;
  localparam int unsigned IRQ_ID_W   = 5;
  localparam int unsigned FAST_IRQ_W = 15;

  localparam int unsigned IRQ_SW_BIT    = 3;
  localparam int unsigned IRQ_TIMER_BIT = 7;
  localparam int unsigned IRQ_EXT_BIT   = 11;
  // fast interrupt k sits at FAST_IRQ_BASE + k
  localparam int unsigned FAST_IRQ_BASE = 16;

  // power domains
  localparam int unsigned DOM_IDX_W   = 4;
  localparam int unsigned MAX_DOMAINS = 2 ** DOM_IDX_W;

  localparam int unsigned DOM_CPU    = 0;
  localparam int unsigned DOM_PERIPH = 1;
  // memory bank b follows as domain DOM_PERIPH + 1 + b

endpackage

`default_nettype wire

// ==== logic/pwr_pkg.sv ====
/*
 * Power-control types. All controls are active low, so all ones is a
 * running domain. Commands are one-cycle strobes with no handshake.
 */
`default_nettype none

package pwr_pkg;

  // field order gives the 4-bit literals used by the sequencer
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
  } pwr_ctrl_out_t;

  localparam pwr_ctrl_out_t PWR_CTRL_ON = 4'b1111;

  typedef enum logic [2:0] {
    ST_ON,
    ST_CLK_OFF,
    ST_ISO_ON,
    ST_RST_ON,
    ST_SW_OFF_WAIT,
    ST_OFF,
    ST_SW_ON_WAIT,
    ST_ISO_OFF
  } pwr_state_e;

  typedef enum logic [1:0] {
    PWR_NOP = 2'd0,
    PWR_OFF = 2'd1,
    PWR_ON  = 2'd2
  } pwr_op_e;

  typedef struct packed {
    logic                              valid;
    pwr_op_e                           op;
    logic [mcu_cfg_pkg::DOM_IDX_W-1:0] dom;
  } pwr_cmd_t;

endpackage

`default_nettype wire

// ==== logic/pwr_domain_fsm.sv ====
/*
 * Sequencer for one switchable domain. Requests count only in ST_ON or ST_OFF.
 * ack_n_i is the switch level and must lag pwrgate_en_n by at least one cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module pwr_domain_fsm
  import pwr_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          off_req_i,
  input  logic          on_req_i,
  input  logic          ack_n_i,
  output pwr_ctrl_out_t ctrl_o,
  output logic          off_o
);

  pwr_state_e    state_q;
  pwr_state_e    state_d;
  pwr_ctrl_out_t ctrl_d;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_ON: begin
        if (off_req_i) state_d = ST_CLK_OFF;
      end
      ST_CLK_OFF:     state_d = ST_ISO_ON;
      ST_ISO_ON:      state_d = ST_RST_ON;
      ST_RST_ON:      state_d = ST_SW_OFF_WAIT;
      ST_SW_OFF_WAIT: begin
        // switch reports the rail is down
        if (!ack_n_i) state_d = ST_OFF;
      end
      ST_OFF: begin
        if (on_req_i) state_d = ST_SW_ON_WAIT;
      end
      ST_SW_ON_WAIT: begin
        if (ack_n_i) state_d = ST_ISO_OFF;
      end
      ST_ISO_OFF:     state_d = ST_ON;
      default:        state_d = ST_ON;
    endcase
  end

  // {pwrgate, iso, rst, clkgate}, one edge behind the state
  always_comb begin
    ctrl_d = PWR_CTRL_ON;
    unique case (state_q)
      ST_ON:          ctrl_d = 4'b1111;
      ST_CLK_OFF:     ctrl_d = 4'b1110;
      ST_ISO_ON:      ctrl_d = 4'b1010;
      ST_RST_ON:      ctrl_d = 4'b1000;
      ST_SW_OFF_WAIT: ctrl_d = 4'b0000;
      ST_OFF:         ctrl_d = 4'b0000;
      ST_SW_ON_WAIT:  ctrl_d = 4'b1000;
      ST_ISO_OFF:     ctrl_d = 4'b1100;
      default:        ctrl_d = PWR_CTRL_ON;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_ON;
      ctrl_o  <= PWR_CTRL_ON;
      off_o   <= 1'b0;
    end else begin
      state_q <= state_d;
      ctrl_o  <= ctrl_d;
      off_o   <= (state_q == ST_OFF);
    end
  end

  // manager resolves direction before requesting
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(off_req_i && on_req_i));

  // rail may only drop behind closed isolation
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !ctrl_o.pwrgate_en_n |-> !ctrl_o.isogate_en_n);

endmodule

`default_nettype wire

// ==== logic/power_manager.sv ====
/*
 * One sequencer per domain: CPU, peripherals, then NUM_BANKS memory banks.
 * Commands that find the domain busy or out of range are dropped. There is no queue.
 * Domain resets are also held low while ndmreset_n_i is low.
 */
`timescale 1ns/1ps
`default_nettype none

module power_manager
  import mcu_cfg_pkg::*;
  import pwr_pkg::*;
#(
  parameter  int unsigned NUM_BANKS = 2,
  localparam int unsigned NUM_DOM   = DOM_PERIPH + 1 + NUM_BANKS
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        ndmreset_n_i,
  input  pwr_cmd_t                    cmd_i,
  input  logic                        core_sleep_i,
  input  logic                        wake_i,
  input  logic          [NUM_DOM-1:0] ack_n_i,
  output pwr_ctrl_out_t [NUM_DOM-1:0] ctrl_o,
  output logic          [NUM_DOM-1:0] domain_off_o
);

  pwr_ctrl_out_t [NUM_DOM-1:0] seq_ctrl;
  logic          [NUM_DOM-1:0] off_req;
  logic          [NUM_DOM-1:0] on_req;
  logic          [NUM_DOM-1:0] is_on;
  logic          [NUM_DOM-1:0] is_off;
  // requested end state per domain, high after an accepted power-down
  logic          [NUM_DOM-1:0] tgt_off_q;
  logic                        dom_ok;

  assign dom_ok = cmd_i.valid && (32'(cmd_i.dom) < NUM_DOM);

  for (genvar d = 0; d < NUM_DOM; d++) begin : gen_dom
    logic hit;
    logic sleep_ok;

    // sequencer outputs trail its state by one edge. Looking only for the
    // requested end state keeps a stale decode from reading as idle
    assign is_on[d]  = !tgt_off_q[d] && (&seq_ctrl[d]);
    assign is_off[d] = tgt_off_q[d] && domain_off_o[d];

    assign hit      = dom_ok && (cmd_i.dom == DOM_IDX_W'(d));
    assign sleep_ok = (d != DOM_CPU) || core_sleep_i;

    assign off_req[d] = hit && (cmd_i.op == PWR_OFF) && is_on[d] && sleep_ok;
    // pending interrupts bring the CPU domain back by themselves
    assign on_req[d]  = is_off[d] &&
                        ((hit && (cmd_i.op == PWR_ON)) || ((d == DOM_CPU) && wake_i));

    pwr_domain_fsm pwr_domain_fsm_i (
      .clk_i,
      .rst_n_i,
      .off_req_i(off_req[d]),
      .on_req_i (on_req[d]),
      .ack_n_i  (ack_n_i[d]),
      .ctrl_o   (seq_ctrl[d]),
      .off_o    (domain_off_o[d])
    );

    assign ctrl_o[d] = '{
      pwrgate_en_n: seq_ctrl[d].pwrgate_en_n,
      isogate_en_n: seq_ctrl[d].isogate_en_n,
      rst_n:        seq_ctrl[d].rst_n && ndmreset_n_i,
      clkgate_en_n: seq_ctrl[d].clkgate_en_n
    };
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tgt_off_q <= '0;
    end else begin
      tgt_off_q <= (tgt_off_q | off_req) & ~on_req;
    end
  end

  // dom field must reach every domain
  assert property (@(posedge clk_i) NUM_DOM <= MAX_DOMAINS);

  // wake on a sleeping CPU is taken at the next edge and the off bit drops one edge later
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wake_i && is_off[DOM_CPU] |-> ##2 !domain_off_o[DOM_CPU]);

endmodule

`default_nettype wire

// ==== logic/irq_ctrl.sv ====
/*
 * Fast interrupts stay pending until the core acknowledges their id.
 * Software, timer and external lines are levels and pass straight through.
 */
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl
  import mcu_cfg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  irq_software_i,
  input  logic                  irq_timer_i,
  input  logic                  irq_external_i,
  input  logic [FAST_IRQ_W-1:0] fast_irq_i,
  input  logic                  irq_ack_i,
  input  logic [IRQ_ID_W-1:0]   irq_id_i,
  output logic [IRQ_W-1:0]      irq_o,
  output logic                  wake_o
);

  logic [FAST_IRQ_W-1:0] pend_q;
  logic [FAST_IRQ_W-1:0] pend_clr;
  logic                  id_known;

  always_comb begin
    for (int k = 0; k < FAST_IRQ_W; k++) begin
      pend_clr[k] = irq_ack_i && (irq_id_i == IRQ_ID_W'(FAST_IRQ_BASE + k));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q <= '0;
    end else begin
      // set wins when the source is still high
      pend_q <= fast_irq_i | (pend_q & ~pend_clr);
    end
  end

  always_comb begin
    irq_o                              = '0;
    irq_o[IRQ_SW_BIT]                  = irq_software_i;
    irq_o[IRQ_TIMER_BIT]               = irq_timer_i;
    irq_o[IRQ_EXT_BIT]                 = irq_external_i;
    irq_o[FAST_IRQ_BASE +: FAST_IRQ_W] = pend_q;
  end

  assign wake_o = |irq_o;

  // ids that name an implemented vector bit
  assign id_known = (irq_id_i == IRQ_ID_W'(IRQ_SW_BIT)) ||
                    (irq_id_i == IRQ_ID_W'(IRQ_TIMER_BIT)) ||
                    (irq_id_i == IRQ_ID_W'(IRQ_EXT_BIT)) ||
                    ((irq_id_i >= IRQ_ID_W'(FAST_IRQ_BASE)) &&
                     (32'(irq_id_i) < FAST_IRQ_BASE + FAST_IRQ_W));

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_ack_i |-> id_known);

endmodule

`default_nettype wire

// ==== logic/mini_mcu_ctrl.sv ====
/*
 * Always-on control block: domain power sequencing and the machine interrupt vector.
 * A pending interrupt powers the CPU domain back up without a command.
 */
`timescale 1ns/1ps
`default_nettype none

module mini_mcu_ctrl
  import mcu_cfg_pkg::*;
  import pwr_pkg::*;
#(
  parameter  int unsigned NUM_BANKS = 2,
  localparam int unsigned NUM_DOM   = DOM_PERIPH + 1 + NUM_BANKS
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        ndmreset_n_i,
  input  pwr_cmd_t                    pwr_cmd_i,
  input  logic                        core_sleep_i,
  input  logic          [NUM_DOM-1:0] pwr_ack_n_i,
  input  logic                        irq_software_i,
  input  logic                        irq_timer_i,
  input  logic                        irq_external_i,
  input  logic       [FAST_IRQ_W-1:0] fast_irq_i,
  input  logic                        irq_ack_i,
  input  logic         [IRQ_ID_W-1:0] irq_id_i,
  output pwr_ctrl_out_t [NUM_DOM-1:0] pwr_ctrl_o,
  output logic          [NUM_DOM-1:0] domain_off_o,
  output logic            [IRQ_W-1:0] irq_o
);

  logic irq_wake;

  power_manager #(
    .NUM_BANKS(NUM_BANKS)
  ) power_manager_i (
    .clk_i,
    .rst_n_i,
    .ndmreset_n_i,
    .cmd_i       (pwr_cmd_i),
    .core_sleep_i,
    .wake_i      (irq_wake),
    .ack_n_i     (pwr_ack_n_i),
    .ctrl_o      (pwr_ctrl_o),
    .domain_off_o
  );

  irq_ctrl irq_ctrl_i (
    .clk_i,
    .rst_n_i,
    .irq_software_i,
    .irq_timer_i,
    .irq_external_i,
    .fast_irq_i,
    .irq_ack_i,
    .irq_id_i,
    .irq_o,
    .wake_o(irq_wake)
  );

endmodule

`default_nettype wire

// ==== include/tb_checks.svh ====
/*
 * Check helpers for the testbench. Include inside the testbench module after
 * clk, pwr_ctrl and domain_off are declared, since wait_domain() watches them.
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int unsigned check_count = 0;
int unsigned error_count = 0;

function automatic void check_eq(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
  check_count++;
  assert (act === exp) else begin
    error_count++;
    $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
  end
endfunction

// bounded wait for domain d to show the given off bit and controls
task automatic wait_domain(input string name, input int d, input logic off_level,
                           input logic [3:0] ctrl, input int unsigned max_cycles);
  int unsigned n;
  n = 0;
  while (!((domain_off[d] === off_level) && (pwr_ctrl[d] === ctrl)) &&
         (n < max_cycles)) begin
    @(posedge clk);
    #1;
    n++;
  end
  check_count++;
  assert ((domain_off[d] === off_level) && (pwr_ctrl[d] === ctrl)) else begin
    error_count++;
    $display("%s: domain %0d never reached off bit %b and controls %b in %0d cycles",
             name, d, off_level, ctrl, max_cycles);
  end
endtask

function automatic void print_counts();
  $display("%0d checks run, %0d errors", check_count, error_count);
endfunction

`endif

// ==== tests/tb_mini_mcu_ctrl.sv ====
/*
 * Directed tests with NUM_BANKS = 2. Switch acknowledges lag pwrgate_en_n
 * by 1 to 5 cycles, picked with $urandom.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mini_mcu_ctrl
  import mcu_cfg_pkg::*;
  import pwr_pkg::*;
();

  localparam int NUM_BANKS = 2;
  localparam int NUM_DOM   = NUM_BANKS + 2;

  logic                        clk;
  logic                        rst_n;
  logic                        ndmreset_n;
  pwr_cmd_t                    pwr_cmd;
  logic                        core_sleep;
  logic          [NUM_DOM-1:0] ack_n;
  logic                        irq_sw;
  logic                        irq_timer;
  logic                        irq_ext;
  logic       [FAST_IRQ_W-1:0] fast_irq;
  logic                        irq_ack;
  logic         [IRQ_ID_W-1:0] irq_id;
  pwr_ctrl_out_t [NUM_DOM-1:0] pwr_ctrl;
  logic          [NUM_DOM-1:0] domain_off;
  logic            [IRQ_W-1:0] irq;

  `include "tb_checks.svh"

  mini_mcu_ctrl #(
    .NUM_BANKS(NUM_BANKS)
  ) dut_i (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .ndmreset_n_i  (ndmreset_n),
    .pwr_cmd_i     (pwr_cmd),
    .core_sleep_i  (core_sleep),
    .pwr_ack_n_i   (ack_n),
    .irq_software_i(irq_sw),
    .irq_timer_i   (irq_timer),
    .irq_external_i(irq_ext),
    .fast_irq_i    (fast_irq),
    .irq_ack_i     (irq_ack),
    .irq_id_i      (irq_id),
    .pwr_ctrl_o    (pwr_ctrl),
    .domain_off_o  (domain_off),
    .irq_o         (irq)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ack follows pwrgate_en_n after a random lag per domain
  initial begin
    int unsigned lag [NUM_DOM];
    ack_n = '1;
    foreach (lag[d]) lag[d] = 0;
    forever begin
      @(posedge clk);
      #1;
      for (int d = 0; d < NUM_DOM; d++) begin
        if (ack_n[d] === pwr_ctrl[d].pwrgate_en_n) begin
          lag[d] = 0;
        end else if (lag[d] == 0) begin
          lag[d] = 1 + ($urandom % 5);
        end else begin
          lag[d]--;
          if (lag[d] == 0) ack_n[d] = pwr_ctrl[d].pwrgate_en_n;
        end
      end
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic send_cmd(input pwr_op_e op, input int dom);
    pwr_cmd.valid = 1'b1;
    pwr_cmd.op    = op;
    pwr_cmd.dom   = 4'(dom);
    step();
    pwr_cmd = '0;
  endtask

  task automatic ack_irq(input int id);
    irq_ack = 1'b1;
    irq_id  = 5'(id);
    step();
    irq_ack = 1'b0;
    irq_id  = '0;
  endtask

  // called right after the accepting edge; mid_cmd is driven for edge 1
  task automatic check_down_order(input string test, input int d, input pwr_cmd_t mid_cmd);
    logic [3:0] exp [5] = '{4'b1111, 4'b1110, 4'b1010, 4'b1000, 4'b0000};
    check_eq($sformatf("%s_edge0", test), 32'(exp[0]), 32'(pwr_ctrl[d]));
    pwr_cmd = mid_cmd;
    for (int e = 1; e < 5; e++) begin
      step();
      pwr_cmd = '0;
      check_eq($sformatf("%s_edge%0d", test, e), 32'(exp[e]), 32'(pwr_ctrl[d]));
    end
    wait_domain(test, d, 1'b1, 4'b0000, 20);
    check_eq({test, "_ack"}, 32'd0, 32'(ack_n[d]));
  endtask

  task automatic check_up_order(input string test, input int d);
    send_cmd(PWR_ON, d);
    step();
    check_eq({test, "_edge1"}, 32'b1000, 32'(pwr_ctrl[d]));
    check_eq({test, "_off_bit"}, 32'd0, 32'(domain_off[d]));
    wait_domain(test, d, 1'b0, 4'b1100, 20);
    check_eq({test, "_ack"}, 32'd1, 32'(ack_n[d]));
    step();
    check_eq({test, "_on"}, 32'b1111, 32'(pwr_ctrl[d]));
  endtask

  // nothing may move for a few cycles
  task automatic hold_steady(input string test, input int cycles);
    repeat (cycles) begin
      step();
      check_eq({test, "_off"}, 32'd0, 32'(domain_off));
      for (int d = 0; d < NUM_DOM; d++) begin
        check_eq($sformatf("%s_ctrl%0d", test, d), 32'b1111, 32'(pwr_ctrl[d]));
      end
    end
  endtask

  task automatic test_reset_state();
    for (int d = 0; d < NUM_DOM; d++) begin
      check_eq($sformatf("reset_ctrl%0d", d), 32'b1111, 32'(pwr_ctrl[d]));
    end
    check_eq("reset_off", 32'd0, 32'(domain_off));
    check_eq("reset_irq", 32'd0, irq);
  endtask

  task automatic test_periph_cycle();
    send_cmd(PWR_OFF, 1);
    check_down_order("periph_off", 1, '0);
    check_up_order("periph_on", 1);
  endtask

  task automatic test_ignored_cmds();
    send_cmd(PWR_OFF, 0);
    hold_steady("cpu_awake", 8);
    send_cmd(PWR_OFF, 9);
    hold_steady("bad_dom", 8);
    // PWR_ON strobe while bank 0 is still going down
    send_cmd(PWR_OFF, 2);
    check_down_order("bank_mid_on", 2, pwr_cmd_t'{valid: 1'b1, op: PWR_ON, dom: 4'd2});
    step();
    step();
    check_eq("bank_stays_off", 32'd1, 32'(domain_off[2]));
    check_up_order("bank_restore", 2);
  endtask

  task automatic test_reset_gating();
    ndmreset_n = 1'b0;
    #1;
    for (int d = 0; d < NUM_DOM; d++) begin
      check_eq($sformatf("ndm_low%0d", d), 32'b1101, 32'(pwr_ctrl[d]));
    end
    ndmreset_n = 1'b1;
    #1;
    for (int d = 0; d < NUM_DOM; d++) begin
      check_eq($sformatf("ndm_high%0d", d), 32'b1111, 32'(pwr_ctrl[d]));
    end
  endtask

  task automatic test_irq_vector();
    int unsigned k;
    k = $urandom % 15;
    step();
    irq_sw = 1'b1;
    #1;
    check_eq("irq_sw", 32'd1 << 3, irq);
    irq_sw = 1'b0;
    step();
    irq_timer = 1'b1;
    #1;
    check_eq("irq_timer", 32'd1 << 7, irq);
    irq_timer = 1'b0;
    step();
    irq_ext = 1'b1;
    #1;
    check_eq("irq_ext", 32'd1 << 11, irq);
    irq_ext = 1'b0;
    step();
    fast_irq[k] = 1'b1;
    step();
    fast_irq = '0;
    check_eq("fast_set", 32'd1 << (16 + k), irq);
    step();
    step();
    check_eq("fast_held", 32'd1 << (16 + k), irq);
    ack_irq(16 + k);
    check_eq("fast_clear", 32'd0, irq);
    // source still high at the ack edge
    fast_irq[k] = 1'b1;
    ack_irq(16 + k);
    fast_irq = '0;
    check_eq("fast_set_wins", 32'd1 << (16 + k), irq);
    ack_irq(16 + k);
    check_eq("fast_final_clear", 32'd0, irq);
  endtask

  task automatic test_wake();
    core_sleep = 1'b1;
    send_cmd(PWR_OFF, 0);
    check_down_order("cpu_off", 0, '0);
    core_sleep = 1'b0;
    check_eq("wake_quiet", 32'd0, irq);
    fast_irq[0] = 1'b1;
    step();
    fast_irq = '0;
    check_eq("wake_pending", 32'd1 << 16, irq);
    // wake is taken at the next edge, the switch opens one edge later
    step();
    check_eq("wake_e1_gate", 32'd0, 32'(pwr_ctrl[0].pwrgate_en_n));
    check_eq("wake_e1_off", 32'd1, 32'(domain_off[0]));
    step();
    check_eq("wake_e2_gate", 32'd1, 32'(pwr_ctrl[0].pwrgate_en_n));
    check_eq("wake_e2_off", 32'd0, 32'(domain_off[0]));
    wait_domain("wake_up", 0, 1'b0, 4'b1111, 20);
    ack_irq(16);
  endtask

  initial begin
    void'($urandom(65599));
    rst_n      = 1'b0;
    ndmreset_n = 1'b1;
    pwr_cmd    = '0;
    core_sleep = 1'b0;
    irq_sw     = 1'b0;
    irq_timer  = 1'b0;
    irq_ext    = 1'b0;
    fast_irq   = '0;
    irq_ack    = 1'b0;
    irq_id     = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset_state();
    test_periph_cycle();
    test_ignored_cmds();
    test_reset_gating();
    test_irq_vector();
    test_wake();
    print_counts();
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #20000;
    $display("simulation did not finish within 20000 ns");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
logic/mcu_cfg_pkg.sv
logic/pwr_pkg.sv
logic/pwr_domain_fsm.sv
logic/power_manager.sv
logic/irq_ctrl.sv
logic/mini_mcu_ctrl.sv
tests/tb_mini_mcu_ctrl.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_mini_mcu_ctrl
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
